// File: acq_pkg.sv
package acq_pkg;

    ////////////////////////////////////////
    // widths
    localparam int SAMPLE_W    = 12;                       // one adc sample
    localparam int CBUF_DW     = 2 * SAMPLE_W + 2;         // sample pair plus two over-range bits
    localparam int BURST_WORDS = 4;                        // buffer words per burst
    localparam int BURST_DW    = BURST_WORDS * CBUF_DW;    // 104 bit burst
    localparam int TAG_W       = 4;
    localparam int PAYLOAD_W   = 128;
    localparam int TRIG_ADDR_W = 16;                       // trigger address field in the header

    ////////////////////////////////////////
    // vector types
    typedef logic [SAMPLE_W-1:0]          sample_t;
    // bit 0 ovr a, 12:1 sample a, bit 13 ovr b, 25:14 sample b
    typedef logic [CBUF_DW-1:0]           cbuf_word_t;
    typedef logic [15:0]                  pre_trig_t;      // pre-trigger count in buffer words
    typedef logic [13:0]                  num_bursts_t;    // bursts per waveform
    typedef logic [23:0]                  fill_num_t;
    typedef logic [11:0]                  wfm_num_t;       // waveform number within the fill
    typedef logic [11:0]                  chan_tag_t;
    typedef logic [TAG_W+PAYLOAD_W-1:0]   out_word_t;      // tag in the top nibble

    // output word tags
    localparam logic [TAG_W-1:0] TAG_HDR  = 4'd1;
    localparam logic [TAG_W-1:0] TAG_DATA = 4'd2;
    localparam logic [TAG_W-1:0] TAG_CSUM = 4'd3;

    ////////////////////////////////////////
    // readout FSM
    typedef enum logic [2:0] {
        IDLE,   // wait for a queued trigger
        POP,    // take the fifo head, start the subtract
        LOAD,   // load read address and burst count, send header
        READ,   // four buffer reads plus the ram latency
        EMIT,   // send one burst
        CSUM    // send the checksum
    } readout_state_t;

endpackage

// File: sample_capture.sv
module sample_capture #(
    parameter int CBUF_AW = 10                  // buffer address width
) (
    input  logic                adc_clk,
    input  logic                rst,
    input  logic                acq_enable,     // write samples while high
    input  logic                acq_trig,       // trigger level
    input  acq_pkg::sample_t    sample_a,       // first sample of the pair
    input  acq_pkg::sample_t    sample_b,       // second sample
    input  logic                ovr_a,          // over-range for sample_a
    input  logic                ovr_b,          // over-range for sample_b
    output logic                acq_enabled,    // registered enable
    output logic                wr_en,
    output logic [CBUF_AW-1:0]  wr_addr,
    output acq_pkg::cbuf_word_t wr_data,
    output logic                trig_push,      // one cycle per trigger edge
    output logic [CBUF_AW-1:0]  trig_addr_in    // write address of the trigger pair
);

    logic en_q;     // enable, aligned with wr_data
    logic trig_q;   // trigger level, aligned with wr_data
    logic trig_qq;  // previous level for edge detect

    ////////////////////////////////////////
    // input registers
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            en_q    <= 1'b0;
            trig_q  <= 1'b0;
            trig_qq <= 1'b0;
        end else begin
            en_q    <= acq_enable;
            trig_q  <= acq_trig;
            trig_qq <= trig_q;
        end
    end

    // pack the pair, first sample in the low half
    always_ff @(posedge adc_clk) begin
        wr_data <= {sample_b, ovr_b, sample_a, ovr_a};
    end

    // free-running write address, wraps at the buffer depth
    always_ff @(posedge adc_clk) begin
        if (rst)
            wr_addr <= '0;
        else if (en_q)
            wr_addr <= wr_addr + 1'b1;
    end

    assign acq_enabled  = en_q;
    assign wr_en        = en_q;
    assign trig_push    = trig_q & ~trig_qq & en_q;    // rising edge, only while enabled
    assign trig_addr_in = wr_addr;                     // address the trigger pair goes to

endmodule

// File: trigger_fifo.sv
module trigger_fifo #(
    parameter int TFIFO_DEPTH = 4,      // number of queued triggers
    parameter int CBUF_AW     = 10      // width of a stored address
) (
    input  logic               adc_clk,
    input  logic               rst,
    input  logic               push,        // store push_addr
    input  logic [CBUF_AW-1:0] push_addr,
    input  logic               pop,         // drop the head
    output logic [CBUF_AW-1:0] head_addr,   // oldest entry, valid while !empty
    output logic               empty
);

    localparam int PTR_W = (TFIFO_DEPTH > 1) ? $clog2(TFIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(TFIFO_DEPTH + 1);

    logic [CBUF_AW-1:0] mem [TFIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && (count != CNT_W'(TFIFO_DEPTH));   // full push is dropped
    assign do_pop  = pop && (count != '0);

    ////////////////////////////////////////
    // storage
    always_ff @(posedge adc_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_addr;
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(TFIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(TFIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    // occupancy, push and pop together leave it unchanged
    always_ff @(posedge adc_clk) begin
        if (rst)
            count <= '0;
        else if (do_push && !do_pop)
            count <= count + 1'b1;
        else if (do_pop && !do_push)
            count <= count - 1'b1;
    end

    // first word falls through
    assign head_addr = mem[rd_ptr];
    assign empty     = (count == '0);

endmodule

// File: circ_buffer.sv
module circ_buffer #(
    parameter int CBUF_AW = 10      // depth is 2**CBUF_AW words
) (
    input  logic                adc_clk,
    input  logic                wr_en,
    input  logic [CBUF_AW-1:0]  wr_addr,
    input  acq_pkg::cbuf_word_t wr_data,
    input  logic [CBUF_AW-1:0]  rd_addr,
    output acq_pkg::cbuf_word_t rd_data     // one cycle after rd_addr
);

    import acq_pkg::*;

    cbuf_word_t mem [2**CBUF_AW];   // simple dual-port block ram

    // write port
    always_ff @(posedge adc_clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read port
    always_ff @(posedge adc_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: readout_sm.sv
module readout_sm #(
    parameter int CBUF_AW = 10
) (
    input  logic                          adc_clk,
    input  logic                          rst,
    input  logic                          fifo_empty,     // no trigger queued
    input  logic [CBUF_AW-1:0]            trig_addr,      // fifo head
    input  acq_pkg::cbuf_word_t           rd_data,        // buffer read data
    input  acq_pkg::pre_trig_t            pre_trig,
    input  acq_pkg::num_bursts_t          num_bursts,
    output logic                          fifo_pop,
    output logic [CBUF_AW-1:0]            rd_addr,
    output logic                          hdr_strobe,     // send the waveform header
    output logic [CBUF_AW-1:0]            hdr_trig_addr,
    output logic                          data_strobe,    // send burst_data
    output logic [acq_pkg::BURST_DW-1:0]  burst_data,     // earliest word in the low bits
    output logic                          csum_strobe,    // send the checksum
    output logic                          sm_idle
);

    import acq_pkg::*;

    localparam int CNT_W = $clog2(BURST_WORDS + 1);

    readout_state_t     state;
    readout_state_t     next_state;
    logic [CBUF_AW-1:0] start_addr;     // first word of the waveform
    num_bursts_t        burst_cnt;      // bursts still to send
    logic [CNT_W-1:0]   word_cnt;       // reads issued in this burst
    logic               issue;          // a read address goes to the ram
    logic               rd_valid;       // rd_data holds a requested word
    cbuf_word_t         shreg [BURST_WORDS];

    ////////////////////////////////////////
    // state register and next state
    always_ff @(posedge adc_clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (!fifo_empty) next_state = POP;
            POP:  next_state = LOAD;
            LOAD: next_state = (num_bursts == '0) ? CSUM : READ;   // empty waveform
            READ: begin
                // last word is back from the ram once all four are issued
                if (word_cnt == CNT_W'(BURST_WORDS))
                    next_state = EMIT;
            end
            EMIT: next_state = (burst_cnt == num_bursts_t'(1)) ? CSUM : READ;
            CSUM: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign issue = (state == READ) && (word_cnt != CNT_W'(BURST_WORDS));

    ////////////////////////////////////////
    // address path
    always_ff @(posedge adc_clk) begin
        if (state == POP) begin
            hdr_trig_addr <= trig_addr;
            start_addr    <= trig_addr - CBUF_AW'(pre_trig);   // wraps modulo the depth
        end
    end

    always_ff @(posedge adc_clk) begin
        if (state == LOAD)
            rd_addr <= start_addr;
        else if (issue)
            rd_addr <= rd_addr + 1'b1;      // runs on across bursts
    end

    // counters
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            burst_cnt <= '0;
            word_cnt  <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= issue;              // ram latency of one cycle
            if (state != READ)
                word_cnt <= '0;
            else if (issue)
                word_cnt <= word_cnt + 1'b1;
            if (state == LOAD)
                burst_cnt <= num_bursts;
            else if (state == EMIT)
                burst_cnt <= burst_cnt - 1'b1;
        end
    end

    // four-word shift register, newest word enters at the top
    always_ff @(posedge adc_clk) begin
        if (rd_valid) begin
            shreg[BURST_WORDS-1] <= rd_data;
            for (int i = 0; i < BURST_WORDS - 1; i++) begin
                shreg[i] <= shreg[i+1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BURST_WORDS; i++) begin
            burst_data[i*CBUF_DW +: CBUF_DW] = shreg[i];
        end
    end

    ////////////////////////////////////////
    // strobes, one state each so never two at once
    assign fifo_pop    = (state == POP);
    assign hdr_strobe  = (state == LOAD);
    assign data_strobe = (state == EMIT);
    assign csum_strobe = (state == CSUM);
    assign sm_idle     = (state == IDLE);

endmodule

// File: record_formatter.sv
module record_formatter #(
    parameter int CBUF_AW = 10
) (
    input  logic                          adc_clk,
    input  logic                          rst,
    input  acq_pkg::chan_tag_t            channel_tag,
    input  acq_pkg::fill_num_t            initial_fill_num,
    input  logic                          initial_fill_num_wr,    // load strobe
    input  acq_pkg::pre_trig_t            pre_trig,
    input  acq_pkg::num_bursts_t          num_bursts,
    input  logic                          hdr_strobe,
    input  logic [CBUF_AW-1:0]            hdr_trig_addr,
    input  logic                          data_strobe,
    input  logic [acq_pkg::BURST_DW-1:0]  burst_data,
    input  logic                          csum_strobe,
    output acq_pkg::out_word_t            out_data,
    output logic                          out_valid,      // one cycle per word
    output logic                          acq_done,       // with the checksum word
    output acq_pkg::fill_num_t            fill_num
);

    import acq_pkg::*;

    wfm_num_t               wfm_num;        // waveforms since the last fill load
    logic [PAYLOAD_W-1:0]   hdr_payload;
    logic [PAYLOAD_W-1:0]   data_payload;
    logic [PAYLOAD_W-1:0]   csum;           // running xor of data payloads

    ////////////////////////////////////////
    // payloads, lsb first: fill, wfm, tag, bursts, pre-trigger, trigger address
    assign hdr_payload = PAYLOAD_W'({TRIG_ADDR_W'(hdr_trig_addr), pre_trig, num_bursts,
                                     channel_tag, wfm_num, fill_num});
    assign data_payload = PAYLOAD_W'(burst_data);

    // output word register
    always_ff @(posedge adc_clk) begin
        if (hdr_strobe)
            out_data <= {TAG_HDR, hdr_payload};
        else if (data_strobe)
            out_data <= {TAG_DATA, data_payload};
        else if (csum_strobe)
            out_data <= {TAG_CSUM, csum};
    end

    // checksum restarts with each header
    always_ff @(posedge adc_clk) begin
        if (hdr_strobe)
            csum <= '0;
        else if (data_strobe)
            csum <= csum ^ data_payload;
    end

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            acq_done  <= 1'b0;
        end else begin
            out_valid <= hdr_strobe | data_strobe | csum_strobe;
            acq_done  <= csum_strobe;
        end
    end

    ////////////////////////////////////////
    // fill and waveform counters, step the cycle after the checksum word
    always_ff @(posedge adc_clk) begin
        if (rst) begin
            fill_num <= '0;
            wfm_num  <= '0;
        end else if (initial_fill_num_wr) begin     // load wins over the step
            fill_num <= initial_fill_num;
            wfm_num  <= '0;
        end else if (acq_done) begin
            fill_num <= fill_num + 1'b1;
            wfm_num  <= wfm_num + 1'b1;
        end
    end

endmodule

// File: adc_acq_top.sv
module adc_acq_top #(
    parameter int CBUF_AW     = 10,     // buffer address width
    parameter int TFIFO_DEPTH = 4       // queued triggers
) (
    input  logic                  adc_clk,
    input  logic                  rst,
    input  logic                  acq_enable,
    input  logic                  acq_trig,
    input  acq_pkg::sample_t      sample_a,
    input  acq_pkg::sample_t      sample_b,
    input  logic                  ovr_a,
    input  logic                  ovr_b,
    input  acq_pkg::chan_tag_t    channel_tag,          // copied into each header
    input  acq_pkg::fill_num_t    initial_fill_num,
    input  logic                  initial_fill_num_wr,
    input  acq_pkg::pre_trig_t    pre_trig,             // words kept before the trigger
    input  acq_pkg::num_bursts_t  num_bursts,           // four-word bursts per waveform
    output logic                  acq_enabled,
    output acq_pkg::out_word_t    out_data,             // tag plus payload
    output logic                  out_valid,
    output logic                  acq_done,
    output acq_pkg::fill_num_t    fill_num,
    output logic                  sm_idle
);

    import acq_pkg::*;

    // buffer write side
    logic               wr_en;
    logic [CBUF_AW-1:0] wr_addr;
    cbuf_word_t         wr_data;
    // trigger queue
    logic               trig_push;
    logic [CBUF_AW-1:0] trig_addr_in;
    logic [CBUF_AW-1:0] head_addr;
    logic               fifo_empty;
    logic               fifo_pop;
    // buffer read side
    logic [CBUF_AW-1:0] rd_addr;
    cbuf_word_t         rd_data;
    // readout to formatter
    logic               hdr_strobe;
    logic [CBUF_AW-1:0] hdr_trig_addr;
    logic               data_strobe;
    logic [BURST_DW-1:0] burst_data;
    logic               csum_strobe;

    ////////////////////////////////////////
    sample_capture #(.CBUF_AW(CBUF_AW)) u_capture (
        .adc_clk, .rst, .acq_enable, .acq_trig,
        .sample_a, .sample_b, .ovr_a, .ovr_b,
        .acq_enabled, .wr_en, .wr_addr, .wr_data,
        .trig_push, .trig_addr_in
    );

    trigger_fifo #(.TFIFO_DEPTH(TFIFO_DEPTH), .CBUF_AW(CBUF_AW)) u_trig_fifo (
        .adc_clk, .rst,
        .push      (trig_push),
        .push_addr (trig_addr_in),
        .pop       (fifo_pop),
        .head_addr (head_addr),
        .empty     (fifo_empty)
    );

    circ_buffer #(.CBUF_AW(CBUF_AW)) u_cbuf (
        .adc_clk, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data
    );

    readout_sm #(.CBUF_AW(CBUF_AW)) u_readout (
        .adc_clk, .rst, .fifo_empty,
        .trig_addr (head_addr),
        .rd_data, .pre_trig, .num_bursts,
        .fifo_pop, .rd_addr, .hdr_strobe, .hdr_trig_addr,
        .data_strobe, .burst_data, .csum_strobe, .sm_idle
    );

    record_formatter #(.CBUF_AW(CBUF_AW)) u_formatter (
        .adc_clk, .rst, .channel_tag, .initial_fill_num, .initial_fill_num_wr,
        .pre_trig, .num_bursts, .hdr_strobe, .hdr_trig_addr,
        .data_strobe, .burst_data, .csum_strobe,
        .out_data, .out_valid, .acq_done, .fill_num
    );

endmodule

// File: adc_acq_assertions.sv
module adc_acq_assertions (
    input logic               adc_clk,
    input logic               rst,
    input logic               out_valid,
    input logic               acq_done,
    input acq_pkg::out_word_t out_data,
    input logic               sm_idle
);

    timeunit 1ns;
    timeprecision 1ps;

    import acq_pkg::*;

    ////////////////////////////////////////
    // the checksum word closes every record
    a_done_with_csum: assert property (@(posedge adc_clk) disable iff (rst)
        acq_done |-> out_valid && (out_data[TAG_W+PAYLOAD_W-1 -: TAG_W] == TAG_CSUM))
        else $error("acq_done without a checksum word on the output");

    // one cycle after the last word the FSM is quiet
    a_idle_quiet: assert property (@(posedge adc_clk) disable iff (rst)
        sm_idle ##1 sm_idle |-> !out_valid)
        else $error("out_valid while the readout FSM sat idle");

    a_valid_known: assert property (@(posedge adc_clk) disable iff (rst)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

endmodule

bind adc_acq_top adc_acq_assertions u_checks (
    .adc_clk, .rst, .out_valid, .acq_done, .out_data, .sm_idle
);

// File: tb_adc_acq.sv
module tb_adc_acq;

    timeunit 1ns;
    timeprecision 1ps;

    import acq_pkg::*;

    localparam int CBUF_AW = 10;
    localparam int DEPTH   = 1 << CBUF_AW;

    // DUT ports
    logic        adc_clk = 1'b0;
    logic        rst;
    logic        acq_enable;
    logic        acq_trig;
    sample_t     sample_a;
    sample_t     sample_b;
    logic        ovr_a;
    logic        ovr_b;
    chan_tag_t   channel_tag;
    fill_num_t   initial_fill_num;
    logic        initial_fill_num_wr;
    pre_trig_t   pre_trig;
    num_bursts_t num_bursts;
    logic        acq_enabled;
    out_word_t   out_data;
    logic        out_valid;
    logic        acq_done;
    fill_num_t   fill_num;
    logic        sm_idle;

    cbuf_word_t   model_mem [DEPTH];  // word written at each buffer address
    logic [31:0]  rnd;                // xorshift state
    int           sample_cnt;         // enabled cycles since reset
    int           cycle_cnt;
    int           cycle_limit = 1_000_000;   // replaced once the patterns are read
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           exp_trig [$];       // trigger addresses still owed a record
    int           phase;              // 0 header, 1 data, 2 checksum
    int           rec_start;          // first buffer address of the record
    int           burst_idx;
    int           records_done;
    logic [127:0] run_csum;
    fill_num_t    exp_fill;
    wfm_num_t     exp_wfm;
    int           cfg_pt;
    int           cfg_nb;
    int           cfg_tag;
    int           cfg_fill;
    // pattern columns
    int p_num [$];
    int p_pos [$];
    int p_pt [$];
    int p_nb [$];
    int p_tag [$];
    int p_fill [$];
    int p_ld [$];
    int p_gap [$];

    adc_acq_top #(.CBUF_AW(CBUF_AW), .TFIFO_DEPTH(4)) uut (.*);

    always #10 adc_clk = ~adc_clk;     // 20 ns period

    // run limit
    always @(posedge adc_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a record never completed", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four consecutive model words with the earliest at the bottom
    function automatic logic [127:0] burst_payload(input int first);
        logic [127:0] p;
        p = '0;
        for (int i = 0; i < BURST_WORDS; i++)
            p[i*26 +: 26] = model_mem[(first + i) % DEPTH];
        return p;
    endfunction

    task automatic check_value(input logic [131:0] got, input logic [131:0] want,
                               input string what);
        if (got !== want) begin
            $display("Mismatch at %0t ns, %s: got %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // one clock with inputs driven at +2 ns and outputs sampled on the falling edge
    task automatic step(input logic trig, input logic fill_wr);
        cbuf_word_t w;
        @(posedge adc_clk);
        #2;
        rnd = xorshift32(rnd);
        w[0]     = rnd[24];       // over-range a
        w[12:1]  = rnd[11:0];     // sample a
        w[13]    = rnd[25];       // over-range b
        w[25:14] = rnd[23:12];    // sample b
        model_mem[sample_cnt % DEPTH] = w;
        sample_cnt++;
        acq_enable          = 1'b1;
        sample_a            = rnd[11:0];
        sample_b            = rnd[23:12];
        ovr_a               = rnd[24];
        ovr_b               = rnd[25];
        acq_trig            = trig;
        initial_fill_num_wr = fill_wr;
        initial_fill_num    = fill_num_t'(cfg_fill);
        pre_trig            = pre_trig_t'(cfg_pt);
        num_bursts          = num_bursts_t'(cfg_nb);
        channel_tag         = chan_tag_t'(cfg_tag);
        @(negedge adc_clk);
        take_output();
    endtask

    // follow the record word by word
    task automatic take_output();
        logic [131:0] want;
        int           trig;
        if (out_valid === 1'b1) begin
            want = '0;
            case (phase)
                0: begin
                    if (exp_trig.size() == 0) begin
                        $display("Output word at %0t ns while no trigger was pending", $time);
                        errors++;
                    end else begin
                        trig = exp_trig.pop_front();
                        want[131:128] = TAG_HDR;
                        want[23:0]    = exp_fill;
                        want[35:24]   = exp_wfm;
                        want[47:36]   = cfg_tag[11:0];
                        want[61:48]   = cfg_nb[13:0];
                        want[77:62]   = cfg_pt[15:0];
                        want[93:78]   = trig[15:0];    // zero-extended address
                        check_value(out_data, want, "header word");
                        rec_start = ((trig - cfg_pt) % DEPTH + DEPTH) % DEPTH;
                        burst_idx = 0;
                        run_csum  = '0;
                        phase     = (cfg_nb == 0) ? 2 : 1;
                    end
                end
                1: begin
                    want = {TAG_DATA, burst_payload(rec_start + BURST_WORDS * burst_idx)};
                    check_value(out_data, want, $sformatf("data word %0d", burst_idx));
                    run_csum ^= want[127:0];
                    burst_idx++;
                    if (burst_idx == cfg_nb)
                        phase = 2;
                end
                default: begin
                    want = {TAG_CSUM, run_csum};
                    check_value(out_data, want, "checksum word");
                    check_value(acq_done, 1, "acq_done with the checksum");
                    exp_fill = exp_fill + 1'b1;
                    exp_wfm  = exp_wfm + 1'b1;
                    records_done++;
                    phase = 0;
                end
            endcase
        end
    endtask

    task automatic report_test(input int num, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d ok", num);
        end else begin
            tests_failed++;
            $display("test %0d FAILED with %0d errors", num, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////
    task automatic run_test(input int k);
        int errs_before;
        int target;
        errs_before = errors;
        cfg_pt  = p_pt[k];
        cfg_nb  = p_nb[k];
        cfg_tag = p_tag[k];
        if (p_ld[k] != 0) begin
            cfg_fill = p_fill[k];
            step(1'b0, 1'b1);
            exp_fill = fill_num_t'(cfg_fill);
            exp_wfm  = '0;
        end
        if (sample_cnt > p_pos[k]) begin
            $display("test %0d cannot place its trigger, position %0d already passed",
                     p_num[k], p_pos[k]);
            errors++;
        end
        while (sample_cnt < p_pos[k])
            step(1'b0, 1'b0);
        exp_trig.push_back(sample_cnt % DEPTH);   // address of the pair seen with the edge
        target = records_done + 1;
        step(1'b1, 1'b0);
        step(1'b1, 1'b0);
        if (p_gap[k] > 0) begin
            repeat (p_gap[k] - 2) step(1'b0, 1'b0);
            exp_trig.push_back(sample_cnt % DEPTH);
            target++;
            step(1'b1, 1'b0);
            step(1'b1, 1'b0);
        end
        while (records_done < target)
            step(1'b0, 1'b0);
        repeat (4) step(1'b0, 1'b0);
        check_value(fill_num, exp_fill, "fill_num after the record");
        check_value(sm_idle, 1, "sm_idle after the record");
        check_value(acq_enabled, 1, "acq_enabled while sampling");
        report_test(p_num[k], errs_before);
    endtask

    initial begin
        int    fd;
        string line;
        int    f [8];
        int    errs_before;
        int    prev_pos;
        rst = 1'b1;
        acq_enable = 1'b0;
        acq_trig = 1'b0;
        sample_a = '0;
        sample_b = '0;
        ovr_a = 1'b0;
        ovr_b = 1'b0;
        channel_tag = '0;
        initial_fill_num = '0;
        initial_fill_num_wr = 1'b0;
        pre_trig = '0;
        num_bursts = '0;
        rnd = 32'ha5ff_35ce;
        exp_fill = '0;
        exp_wfm = '0;
        prev_pos = 0;
        fd = $fopen("acq_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open acq_patterns.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            cycle_limit = 100;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%d %d %d %d %h %h %d %d", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7]) == 8) begin
                    p_num.push_back(f[0]);
                    p_pos.push_back(f[1]);
                    p_pt.push_back(f[2]);
                    p_nb.push_back(f[3]);
                    p_tag.push_back(f[4]);
                    p_fill.push_back(f[5]);
                    p_ld.push_back(f[6]);
                    p_gap.push_back(f[7]);
                    cycle_limit += (f[1] - prev_pos) + f[7] + 50;     // cycles up to the trigger
                    cycle_limit += 8 * f[3] * ((f[7] > 0) ? 2 : 1);   // one or two records
                    prev_pos = f[1];
                end
            end
            $fclose(fd);
            repeat (10) @(posedge adc_clk);
            #2;
            rst = 1'b0;
            @(negedge adc_clk);
            errs_before = errors;   // reset state before the first enabled cycle
            check_value(out_valid, 0, "out_valid after reset");
            check_value(acq_done, 0, "acq_done after reset");
            check_value(acq_enabled, 0, "acq_enabled after reset");
            check_value(sm_idle, 1, "sm_idle after reset");
            report_test(0, errs_before);
            foreach (p_num[k])
                run_test(k);
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0 && tests_run > 1)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

// File: acq_patterns.txt
# test  trig_pos  pre_trig  num_bursts  channel_tag  fill_num  load_fill  gap
# trig_pos counts enabled cycles from reset, tag and fill in hex, gap 0 means one trigger
# 3 and 6 start reading below address zero, 4 and 5 queue a second trigger
1    100    16    4   0a1  000100  1   0
2    200     8    8   123  000000  0   0
3   1030    40   16   2b7  000000  0   0
4   1200    20    6   3c3  000000  0  10
5   1400     8    2   5a5  abcdef  1   6
6   2050   100   32   7e1  000000  0   0
7   2400     8    1   fff  000000  0   0
8   2600   512   64   444  123456  1   0

// File: all.f
acq_pkg.sv
sample_capture.sv
trigger_fifo.sv
circ_buffer.sv
readout_sm.sv
record_formatter.sv
adc_acq_top.sv
adc_acq_assertions.sv
tb_adc_acq.sv

// File: Bender.yml
package:
  name: adc_acq

sources:
  - acq_pkg.sv
  - sample_capture.sv
  - trigger_fifo.sv
  - circ_buffer.sv
  - readout_sm.sv
  - record_formatter.sv
  - adc_acq_top.sv
  - target: test
    files:
      - adc_acq_assertions.sv
      - tb_adc_acq.sv
